//--- verilog/link_train_pkg.sv
//==========================================================================
// Link training package with state, rate, signaling and failure encodings,
// capability word layout and training constants
//==========================================================================
`default_nettype none

package link_train_pkg;

    typedef enum logic [4:0] {
        RESET, INIT,
        A_START, A_PATTERN, A_LOCK, A_EQ, A_VERIFY,
        B_START, B_PATTERN, B_LOCK, B_EQ, B_VERIFY,
        PARAM_EXCHANGE, FINAL_VERIFY, COMPLETE, FAILED, ERROR_RECOVERY
    } lt_state_t;

    typedef enum logic [1:0] {RATE_32G, RATE_64G, RATE_128G, RATE_OTHER} data_rate_t;
    typedef enum logic [1:0] {SIG_NRZ, SIG_PAM4} signaling_t;
    typedef enum logic [1:0] {PAT_PRBS7, PAT_PRBS15, PAT_PAM4_LEVELS} pattern_t;
    typedef enum logic [1:0] {FAIL_NONE, FAIL_PARAM_MISMATCH, FAIL_RETRIES} fail_reason_t;

    // Capability word exchanged with the link partner
    typedef struct packed {
        logic [3:0] supported_rates; // One bit per data_rate_t value
        signaling_t pref_signaling;
        logic [4:0] max_lanes;
        logic [7:0] eq_caps;
        logic [7:0] train_options;
        logic [4:0] reserved;
    } link_params_t;

    localparam logic [7:0] PHASE_A_ERR_LIMIT   = 8'd10;
    localparam logic [7:0] PHASE_B_ERR_LIMIT   = 8'd5;
    localparam logic [7:0] PHASE_A_SCORE_BASE  = 8'd200;
    localparam logic [7:0] PHASE_B_SCORE_BONUS = 8'd50;
    localparam logic [7:0] QUALITY_PASS        = 8'd200; // Link quality must exceed
    localparam logic [4:0] MIN_REMOTE_LANES    = 5'd8;

    localparam logic [3:0] LOCAL_RATES   = 4'b1111;
    localparam logic [7:0] LOCAL_EQ_CAPS = 8'hFF;
    localparam logic [7:0] LOCAL_OPTIONS = 8'h0F;

    // Phase A length in timer units, longer at higher rates
    function automatic logic [3:0] phase_a_units(input data_rate_t rate);
        case (rate)
            RATE_128G: return 4'd8;
            RATE_64G:  return 4'd6;
            RATE_32G:  return 4'd4;
            default:   return 4'd5;
        endcase
    endfunction

    function automatic logic [3:0] phase_b_units(input signaling_t sig);
        return (sig == SIG_PAM4) ? 4'd15 : 4'd10;
    endfunction

endpackage

`default_nettype wire

//--- verilog/link_train_seq.sv
//==========================================================================
// Link training sequencer with phase FSM, phase timer, retry counter,
// equalization strobes and failure reason
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module link_train_seq
    import link_train_pkg::*;
#(
    parameter int PHASE_UNIT   = 1000,
    parameter int WAIT_TIMEOUT = 10000,
    parameter int MAX_RETRIES  = 3
) (
    input  logic         clk_main,
    input  logic         rst_n,
    input  logic         training_enable,
    input  logic         training_restart,
    input  data_rate_t   target_data_rate,
    input  signaling_t   signaling_mode,
    input  logic         pattern_lock_all,
    input  logic         eq_adaptation_done,
    input  logic         all_a_done,
    input  logic         all_b_done,
    input  logic [7:0]   link_quality,
    input  logic         negotiated,
    input  logic         mismatch,
    output lt_state_t    state,
    output logic         pattern_enable,
    output logic         phase_b_sel,
    output logic         eq_training_enable,
    output logic [1:0]   eq_training_mode,
    output logic         phase_a_active,
    output logic         phase_b_active,
    output logic [3:0]   phase_a_duration,
    output logic [3:0]   phase_b_duration,
    output logic         param_valid,
    output logic         training_complete,
    output logic         training_failed,
    output fail_reason_t failure_reason
);

    localparam int TMR_MAX = (PHASE_UNIT * 15 > WAIT_TIMEOUT) ? PHASE_UNIT * 15 : WAIT_TIMEOUT;
    localparam int TMR_W   = $clog2(TMR_MAX + 1);
    localparam int RTY_W   = $clog2(MAX_RETRIES + 2);

    lt_state_t        next_state;
    logic [TMR_W-1:0] timer;       // Cycles spent in current state
    logic [RTY_W-1:0] retry_cnt;
    logic [3:0]       cur_units;
    logic             pat_expired;
    logic             wait_expired;

    assign cur_units    = phase_b_sel ? phase_b_duration : phase_a_duration;
    assign pat_expired  = (timer == TMR_W'(PHASE_UNIT * cur_units - 1));
    assign wait_expired = (timer == TMR_W'(WAIT_TIMEOUT - 1));

    always_comb begin
        next_state = state;
        case (state)
            RESET: begin
                if (training_enable) next_state = INIT;
            end
            INIT:      next_state = A_START;
            A_START:   next_state = A_PATTERN;
            A_PATTERN: begin
                if (pat_expired) next_state = A_LOCK;
            end
            A_LOCK: begin
                if (pattern_lock_all) next_state = A_EQ;
                else if (wait_expired) next_state = ERROR_RECOVERY;
            end
            A_EQ: begin
                if (eq_adaptation_done) next_state = A_VERIFY;
                else if (wait_expired) next_state = ERROR_RECOVERY;
            end
            A_VERIFY: begin
                if (all_a_done) next_state = B_START;
                else if (wait_expired) next_state = ERROR_RECOVERY;
            end
            B_START:   next_state = B_PATTERN;
            B_PATTERN: begin
                if (pat_expired) next_state = B_LOCK;
            end
            B_LOCK: begin
                if (pattern_lock_all) next_state = B_EQ;
                else if (wait_expired) next_state = ERROR_RECOVERY;
            end
            B_EQ: begin
                if (eq_adaptation_done) next_state = B_VERIFY;
                else if (wait_expired) next_state = ERROR_RECOVERY;
            end
            B_VERIFY: begin
                if (all_b_done) next_state = PARAM_EXCHANGE;
                else if (wait_expired) next_state = ERROR_RECOVERY;
            end
            PARAM_EXCHANGE: begin
                if (mismatch) next_state = FAILED;
                else if (negotiated) next_state = FINAL_VERIFY;
                else if (wait_expired) next_state = ERROR_RECOVERY;
            end
            FINAL_VERIFY: begin
                if (link_quality > QUALITY_PASS) next_state = COMPLETE;
                else if (wait_expired) next_state = ERROR_RECOVERY;
            end
            COMPLETE, FAILED: begin
                if (training_restart) next_state = RESET;
            end
            ERROR_RECOVERY: begin
                next_state = (retry_cnt < RTY_W'(MAX_RETRIES)) ? INIT : FAILED;
            end
            default: next_state = RESET;
        endcase
    end

    always_ff @(posedge clk_main or negedge rst_n) begin
        if (!rst_n) begin
            state            <= RESET;
            timer            <= '0;
            retry_cnt        <= '0;
            phase_a_duration <= '0;
            phase_b_duration <= '0;
            failure_reason   <= FAIL_NONE;
        end else begin
            state <= next_state;
            timer <= (next_state != state) ? '0 : timer + 1'b1; // Restart on every move
            case (state)
                RESET: begin
                    retry_cnt      <= '0; // Only place retries clear
                    failure_reason <= FAIL_NONE;
                end
                A_START: phase_a_duration <= phase_a_units(target_data_rate);
                B_START: phase_b_duration <= phase_b_units(signaling_mode);
                PARAM_EXCHANGE: begin
                    if (mismatch) failure_reason <= FAIL_PARAM_MISMATCH;
                end
                ERROR_RECOVERY: begin
                    if (retry_cnt < RTY_W'(MAX_RETRIES)) retry_cnt <= retry_cnt + 1'b1;
                    else failure_reason <= FAIL_RETRIES;
                end
                default: ;
            endcase
        end
    end

    assign phase_a_active     = (state >= A_START) && (state <= A_VERIFY);
    assign phase_b_active     = (state >= B_START) && (state <= B_VERIFY);
    assign phase_b_sel        = phase_b_active;
    assign pattern_enable     = (state inside {A_PATTERN, A_LOCK, A_EQ,
                                               B_PATTERN, B_LOCK, B_EQ});
    assign eq_training_mode   = {state == B_EQ, state == A_EQ}; // Bit 0 Phase A, bit 1 Phase B
    assign eq_training_enable = |eq_training_mode;
    assign param_valid        = (state == PARAM_EXCHANGE);
    assign training_complete  = (state == COMPLETE);
    assign training_failed    = (state == FAILED);

    a_state_legal: assert property (@(posedge clk_main) disable iff (!rst_n)
        !$isunknown(state) && (state <= ERROR_RECOVERY));

    a_done_fail_excl: assert property (@(posedge clk_main) disable iff (!rst_n)
        !(training_complete && training_failed));

endmodule

`default_nettype wire

//--- verilog/pattern_gen.sv
//==========================================================================
// Per-lane training symbol generator for PRBS7, PRBS15 and PAM4 levels
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module pattern_gen
    import link_train_pkg::*;
#(
    parameter int NUM_LANES = 16
) (
    input  logic                   clk_main,
    input  logic                   rst_n,
    input  logic                   pattern_enable,
    input  logic                   phase_b_sel,
    input  signaling_t             signaling_mode,
    output logic [2*NUM_LANES-1:0] training_pattern
);

    logic [6:0]  prbs7  [NUM_LANES];
    logic [14:0] prbs15 [NUM_LANES];
    logic [1:0]  level;   // PAM4 staircase, shared by all lanes
    pattern_t    pat_sel;

    always_comb begin
        if (!phase_b_sel) pat_sel = PAT_PRBS7;
        else if (signaling_mode == SIG_PAM4) pat_sel = PAT_PAM4_LEVELS;
        else pat_sel = PAT_PRBS15;
    end

    always_ff @(posedge clk_main or negedge rst_n) begin
        if (!rst_n) begin
            level            <= '0;
            training_pattern <= '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                prbs7[i]  <= 7'd1;
                prbs15[i] <= 15'd1;
            end
        end else if (!pattern_enable) begin
            level            <= '0;  // Reseed while idle
            training_pattern <= '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                prbs7[i]  <= 7'd1;
                prbs15[i] <= 15'd1;
            end
        end else begin
            level <= level + 1'b1;
            for (int i = 0; i < NUM_LANES; i++) begin
                case (pat_sel)
                    PAT_PRBS7:  training_pattern[2*i +: 2] <= prbs7[i][1:0];
                    PAT_PRBS15: training_pattern[2*i +: 2] <= prbs15[i][1:0];
                    default:    training_pattern[2*i +: 2] <= level;
                endcase
                prbs7[i]  <= {prbs7[i][5:0], prbs7[i][6] ^ prbs7[i][5]};        // x^7+x^6+1
                prbs15[i] <= {prbs15[i][13:0], prbs15[i][14] ^ prbs15[i][13]};  // x^15+x^14+1
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/lane_verify.sv
//==========================================================================
// Per-lane phase completion flags, quality scores and link quality average
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module lane_verify
    import link_train_pkg::*;
#(
    parameter int NUM_LANES = 16
) (
    input  logic                   clk_main,
    input  logic                   rst_n,
    input  lt_state_t              state,
    input  logic [NUM_LANES-1:0]   pattern_lock,
    input  logic [8*NUM_LANES-1:0] pattern_error_count,
    output logic                   all_a_done,
    output logic                   all_b_done,
    output logic [7:0]             link_quality
);

    localparam int LOG2_LANES = $clog2(NUM_LANES);
    localparam int SUM_W      = 8 + LOG2_LANES;

    logic [NUM_LANES-1:0] a_done;
    logic [NUM_LANES-1:0] b_done;
    logic [7:0]           score [NUM_LANES];
    logic [SUM_W-1:0]     score_sum;

    always_ff @(posedge clk_main or negedge rst_n) begin
        if (!rst_n) begin
            a_done <= '0;
            b_done <= '0;
            for (int i = 0; i < NUM_LANES; i++) score[i] <= '0;
        end else begin
            case (state)
                RESET, INIT: begin
                    a_done <= '0;
                    b_done <= '0;
                    for (int i = 0; i < NUM_LANES; i++) score[i] <= '0;
                end
                A_VERIFY: begin
                    for (int i = 0; i < NUM_LANES; i++) begin
                        if (!a_done[i] && pattern_lock[i] &&
                            pattern_error_count[8*i +: 8] < PHASE_A_ERR_LIMIT) begin
                            a_done[i] <= 1'b1;
                            score[i]  <= PHASE_A_SCORE_BASE - pattern_error_count[8*i +: 8];
                        end
                    end
                end
                B_VERIFY: begin
                    // Bonus added once per lane, Phase A must have passed
                    for (int i = 0; i < NUM_LANES; i++) begin
                        if (!b_done[i] && a_done[i] && pattern_lock[i] &&
                            pattern_error_count[8*i +: 8] < PHASE_B_ERR_LIMIT) begin
                            b_done[i] <= 1'b1;
                            score[i]  <= score[i] + PHASE_B_SCORE_BONUS
                                         - pattern_error_count[8*i +: 8];
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        score_sum = '0;
        for (int i = 0; i < NUM_LANES; i++) score_sum = score_sum + SUM_W'(score[i]);
    end

    assign link_quality = 8'(score_sum >> LOG2_LANES); // Average over lanes
    assign all_a_done   = &a_done;
    assign all_b_done   = &b_done;

    a_b_after_a: assert property (@(posedge clk_main) disable iff (!rst_n)
        $rose(all_b_done) |-> all_a_done);

endmodule

`default_nettype wire

//--- verilog/param_negotiate.sv
//==========================================================================
// Capability word exchange, builds the local word and checks the remote
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module param_negotiate
    import link_train_pkg::*;
#(
    parameter int NUM_LANES = 16
) (
    input  logic        clk_main,
    input  logic        rst_n,
    input  lt_state_t   state,
    input  signaling_t  signaling_mode,
    input  logic [31:0] remote_parameters,
    input  logic        param_ack,
    output logic [31:0] local_parameters,
    output logic        negotiated,
    output logic        mismatch
);

    link_params_t local_word;
    link_params_t remote_word;
    logic         compatible;

    assign remote_word      = link_params_t'(remote_parameters);
    assign local_parameters = local_word;

    assign compatible = (|(local_word.supported_rates & remote_word.supported_rates))
                        && (local_word.pref_signaling == remote_word.pref_signaling)
                        && (remote_word.max_lanes >= MIN_REMOTE_LANES);

    always_ff @(posedge clk_main or negedge rst_n) begin
        if (!rst_n) begin
            local_word <= '0;
            negotiated <= 1'b0;
            mismatch   <= 1'b0;
        end else if (state == INIT) begin
            local_word <= '{supported_rates: LOCAL_RATES,
                            pref_signaling:  signaling_mode,
                            max_lanes:       5'(NUM_LANES),
                            eq_caps:         LOCAL_EQ_CAPS,
                            train_options:   LOCAL_OPTIONS,
                            reserved:        '0};
            negotiated <= 1'b0;
            mismatch   <= 1'b0;
        end else if (state == PARAM_EXCHANGE && param_ack && !negotiated && !mismatch) begin
            negotiated <= compatible;  // First acked cycle decides
            mismatch   <= !compatible;
        end
    end

endmodule

`default_nettype wire

//--- verilog/link_train_top.sv
//==========================================================================
// Link training top, sequencer with pattern, verify and negotiation blocks
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module link_train_top
    import link_train_pkg::*;
#(
    parameter int NUM_LANES    = 16,
    parameter int PHASE_UNIT   = 1000,
    parameter int WAIT_TIMEOUT = 10000,
    parameter int MAX_RETRIES  = 3
) (
    input  logic                   clk_main,
    input  logic                   rst_n,
    input  logic                   training_enable,
    input  logic                   training_restart,
    input  data_rate_t             target_data_rate,
    input  signaling_t             signaling_mode,
    input  logic [NUM_LANES-1:0]   pattern_lock,
    input  logic [8*NUM_LANES-1:0] pattern_error_count,
    output logic                   pattern_enable,
    output logic [2*NUM_LANES-1:0] training_pattern,
    output logic                   eq_training_enable,
    output logic [1:0]             eq_training_mode,
    input  logic                   eq_adaptation_done,
    output logic                   phase_a_active,
    output logic                   phase_b_active,
    output logic [3:0]             phase_a_duration,
    output logic [3:0]             phase_b_duration,
    output logic [31:0]            local_parameters,
    input  logic [31:0]            remote_parameters,
    output logic                   param_valid,
    input  logic                   param_ack,
    output logic [7:0]             training_quality,
    output logic                   training_complete,
    output logic                   training_failed,
    output fail_reason_t           failure_reason
);

    lt_state_t state;
    logic      phase_b_sel;
    logic      pattern_lock_all;
    logic      all_a_done;
    logic      all_b_done;
    logic      negotiated;
    logic      mismatch;

    assign pattern_lock_all = &pattern_lock;

    link_train_seq #(
        .PHASE_UNIT(PHASE_UNIT), .WAIT_TIMEOUT(WAIT_TIMEOUT), .MAX_RETRIES(MAX_RETRIES)
    ) i_seq (
        .clk_main, .rst_n, .training_enable, .training_restart, .target_data_rate,
        .signaling_mode, .pattern_lock_all, .eq_adaptation_done, .all_a_done, .all_b_done,
        .link_quality(training_quality), .negotiated, .mismatch, .state, .pattern_enable,
        .phase_b_sel, .eq_training_enable, .eq_training_mode, .phase_a_active,
        .phase_b_active, .phase_a_duration, .phase_b_duration, .param_valid,
        .training_complete, .training_failed, .failure_reason
    );

    pattern_gen #(.NUM_LANES(NUM_LANES)) i_pattern (
        .clk_main, .rst_n, .pattern_enable, .phase_b_sel, .signaling_mode, .training_pattern
    );

    lane_verify #(.NUM_LANES(NUM_LANES)) i_verify (
        .clk_main, .rst_n, .state, .pattern_lock, .pattern_error_count,
        .all_a_done, .all_b_done, .link_quality(training_quality)
    );

    param_negotiate #(.NUM_LANES(NUM_LANES)) i_negotiate (
        .clk_main, .rst_n, .state, .signaling_mode, .remote_parameters, .param_ack,
        .local_parameters, .negotiated, .mismatch
    );

endmodule

`default_nettype wire

//--- tests/tb_link_train.sv
//==========================================================================
// Link training testbench, clean runs, pattern streams, mismatch and retries
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module tb_link_train
    import link_train_pkg::*;
();

    localparam int NUM_LANES = 4;
    localparam int LIMIT     = 2000; // Cycles allowed for any single wait

    logic clk_main = 1'b0;
    logic rst_n, training_enable, training_restart;
    data_rate_t target_data_rate;
    signaling_t signaling_mode;
    logic [NUM_LANES-1:0]   pattern_lock;
    logic [8*NUM_LANES-1:0] pattern_error_count;
    logic [31:0] remote_parameters, local_parameters;
    logic eq_adaptation_done = 1'b0;
    logic param_ack = 1'b0;
    logic pattern_enable, eq_training_enable, phase_a_active, phase_b_active, param_valid;
    logic training_complete, training_failed;
    logic [2*NUM_LANES-1:0] training_pattern;
    logic [1:0] eq_training_mode;
    logic [3:0] phase_a_duration, phase_b_duration;
    logic [7:0] training_quality;
    fail_reason_t failure_reason;

    logic [31:0] lfsr_state = 32'h566b7f7e;
    logic [7:0]  ea [NUM_LANES];  // Phase A error counts
    logic [7:0]  eb [NUM_LANES];
    logic [6:0]  ref7 = 7'd1;
    logic [14:0] ref15 = 15'd1;
    logic [1:0]  ref_level = 2'd0;
    logic [1:0]  exp_sym;
    logic        sym_pending = 1'b0;
    int errors = 0;
    int symbols = 0;
    int runs = 0;

    link_train_top #(.NUM_LANES(NUM_LANES), .PHASE_UNIT(4), .WAIT_TIMEOUT(64), .MAX_RETRIES(2))
        i_dut (.*);

    always #10 clk_main = ~clk_main;

    // Galois LFSR, one step per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [3:0] exp_a_units(input data_rate_t r);
        if (r == RATE_128G) return 4'd8;
        else if (r == RATE_64G) return 4'd6;
        else if (r == RATE_32G) return 4'd4;
        return 4'd5;
    endfunction

    function automatic logic [3:0] exp_b_units(input signaling_t s);
        return (s == SIG_PAM4) ? 4'd15 : 4'd10;
    endfunction

    function automatic logic [6:0] prbs7_next(input logic [6:0] r);
        return {r[5:0], r[6] ^ r[5]};
    endfunction

    function automatic logic [14:0] prbs15_next(input logic [14:0] r);
        return {r[13:0], r[14] ^ r[13]};
    endfunction

    // Score per lane is 200 - ea + 50 - eb, averaged over lanes
    function automatic logic [7:0] exp_quality();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_LANES; i++) sum = sum + 250 - ea[i] - eb[i];
        return 8'(sum / NUM_LANES);
    endfunction

    // All rates, own signaling and lane count, full eq caps, options 0F
    function automatic logic [31:0] local_caps_word(input signaling_t s);
        return {4'b1111, 2'(s), 5'(NUM_LANES), 8'hFF, 8'h0F, 5'd0};
    endfunction

    // Rates [31:28], signaling [27:26], lanes [25:21]
    function automatic logic negotiate_ok(input logic [31:0] w, input signaling_t s);
        return (w[31:28] != 4'b0) && (w[27:26] == 2'(s)) && (w[25:21] >= 5'd8);
    endfunction

    function automatic logic [31:0] make_remote(input int kind);
        logic [3:0] rates;
        logic [1:0] sig;
        logic [4:0] lanes;
        logic [7:0] eq_caps;
        rates   = 4'(rand_bits(4)) | 4'b0001;
        sig     = (kind == 1) ? (2'(signaling_mode) ^ 2'b01) : 2'(signaling_mode);
        lanes   = (kind == 2) ? 5'(rand_bits(3)) : 5'd8 + 5'(rand_bits(3)); // 2 means too few
        eq_caps = rand_bits(8);
        return {rates, sig, lanes, eq_caps, 8'h0F, 5'd0};
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %s: expected %0h, actual %0h", test, expected, actual);
        errors++;
    endtask

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Summary: runs=%0d symbols=%0d errors=%0d", runs, symbols, errors);
        $display("TEST FAILED");
        $finish;
    endtask

    // Link partner, acks and finishes equalization one cycle after request
    always @(negedge clk_main) begin
        eq_adaptation_done <= eq_training_enable;
        param_ack          <= param_valid;
    end

    always @(negedge clk_main) begin
        if (rst_n && eq_training_enable && !(phase_a_active || phase_b_active)) begin
            $display("[ERROR] eq strobe: enable high outside both training phases");
            errors++;
        end
        if (rst_n && eq_training_mode !== {eq_training_enable && phase_b_active,
                                           eq_training_enable && phase_a_active})
            report_mismatch("eq mode", {eq_training_enable && phase_b_active,
                                        eq_training_enable && phase_a_active},
                            eq_training_mode);
    end

    // Symbol model, one cycle behind pattern_enable
    always @(negedge clk_main) begin
        if (sym_pending) begin
            symbols++;
            for (int i = 0; i < NUM_LANES; i++) begin
                if (training_pattern[2*i +: 2] !== exp_sym)
                    report_mismatch($sformatf("pattern lane %0d", i), exp_sym,
                                    training_pattern[2*i +: 2]);
            end
        end
        if (pattern_enable === 1'b1) begin
            if (!phase_b_active) exp_sym = ref7[1:0];
            else if (signaling_mode == SIG_PAM4) exp_sym = ref_level;
            else exp_sym = ref15[1:0];
            ref7        = prbs7_next(ref7);
            ref15       = prbs15_next(ref15);
            ref_level   = ref_level + 2'd1;
            sym_pending = 1'b1;
        end else begin
            ref7        = 7'd1;  // Generator reseeds while idle
            ref15       = 15'd1;
            ref_level   = 2'd0;
            sym_pending = 1'b0;
        end
    end

    task automatic run_training(input string name, input logic lock, input int kind);
        int n;
        logic neg_ok;
        @(negedge clk_main);
        target_data_rate = data_rate_t'(2'(rand_bits(2)));
        signaling_mode   = signaling_t'({1'b0, rand_bits(1) == 8'd1});
        for (int i = 0; i < NUM_LANES; i++) begin
            ea[i] = rand_bits(3) % 5;
            eb[i] = rand_bits(3) % 5;
            pattern_error_count[8*i +: 8] = ea[i];
        end
        remote_parameters = make_remote(kind);
        neg_ok            = negotiate_ok(remote_parameters, signaling_mode);
        pattern_lock      = lock ? '1 : '0;
        training_enable   = 1'b1;
        runs++;
        n = 0;
        while (!phase_b_active && !training_failed && n < LIMIT) begin
            @(negedge clk_main);
            n++;
        end
        if (n >= LIMIT) abort_run({name, " Phase B"});
        for (int i = 0; i < NUM_LANES; i++) pattern_error_count[8*i +: 8] = eb[i];
        n = 0;
        while (!training_complete && !training_failed && n < LIMIT) begin
            @(negedge clk_main);
            n++;
        end
        if (n >= LIMIT) abort_run({name, " end of training"});
        if (local_parameters !== local_caps_word(signaling_mode))
            report_mismatch({name, " local word"}, local_caps_word(signaling_mode),
                            local_parameters);
        if (lock && neg_ok) begin
            if (training_complete !== 1'b1)
                report_mismatch({name, " complete"}, 1, training_complete);
            if (training_quality !== exp_quality())
                report_mismatch({name, " quality"}, exp_quality(), training_quality);
            if (phase_a_duration !== exp_a_units(target_data_rate))
                report_mismatch({name, " A units"}, exp_a_units(target_data_rate),
                                phase_a_duration);
            if (phase_b_duration !== exp_b_units(signaling_mode))
                report_mismatch({name, " B units"}, exp_b_units(signaling_mode),
                                phase_b_duration);
        end else begin
            if (training_failed !== 1'b1)
                report_mismatch({name, " failed"}, 1, training_failed);
            if (failure_reason !== (lock ? FAIL_PARAM_MISMATCH : FAIL_RETRIES))
                report_mismatch({name, " reason"}, lock ? FAIL_PARAM_MISMATCH : FAIL_RETRIES,
                                failure_reason);
        end
        @(negedge clk_main);
        training_enable  = 1'b0;
        training_restart = 1'b1;
        @(negedge clk_main);
        training_restart = 1'b0;
        n = 0;
        while ((training_complete || training_failed) && n < LIMIT) begin
            @(negedge clk_main);
            n++;
        end
        if (n >= LIMIT) abort_run({name, " return to idle"});
    endtask

    initial begin
        rst_n               = 1'b0;
        training_enable     = 1'b0;
        training_restart    = 1'b0;
        target_data_rate    = RATE_32G;
        signaling_mode      = SIG_NRZ;
        pattern_lock        = '0;
        pattern_error_count = '0;
        remote_parameters   = '0;
        repeat (16) @(posedge clk_main);
        @(negedge clk_main);
        rst_n = 1'b1;
        @(negedge clk_main);
        if ({training_complete, training_failed, phase_a_active, phase_b_active, param_valid,
             eq_training_enable, pattern_enable} !== 7'b0)
            report_mismatch("after reset", 0, {training_complete, training_failed,
                phase_a_active, phase_b_active, param_valid, eq_training_enable, pattern_enable});
        if (failure_reason !== FAIL_NONE)
            report_mismatch("reset reason", FAIL_NONE, failure_reason);
        run_training("clean 1", 1'b1, 0);
        run_training("clean 2", 1'b1, 0);
        run_training("signaling mismatch", 1'b1, 1);
        run_training("lane mismatch", 1'b1, 2);
        run_training("retry limit", 1'b0, 0);
        run_training("clean after retries", 1'b1, 0);
        $display("Summary: runs=%0d symbols=%0d errors=%0d", runs, symbols, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/link_train_pkg.sv
verilog/link_train_seq.sv
verilog/pattern_gen.sv
verilog/lane_verify.sv
verilog/param_negotiate.sv
verilog/link_train_top.sv
tests/tb_link_train.sv

//--- Bender.yml
package:
  name: link_train

sources:
  - verilog/link_train_pkg.sv
  - verilog/link_train_seq.sv
  - verilog/pattern_gen.sv
  - verilog/lane_verify.sv
  - verilog/param_negotiate.sv
  - verilog/link_train_top.sv
  - target: test
    files:
      - tests/tb_link_train.sv
